//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,   // R-type, decoded by funct
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_JR    = 6'h08,
        FN_MFHI  = 6'h10,
        FN_MFLO  = 6'h12,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_format_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_format_t;

    // Same instruction word, two readings
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_MULT  = 4'd7,
        ALU_MULTU = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic [31:0] hi;   // Upper product word
        logic [31:0] lo;   // Product low word or plain result
    } alu_result_t;

endpackage

`default_nettype wire

//--- avalon_pkg.sv
`default_nettype none

package avalon_pkg;

    // Master to slave
    typedef struct packed {
        logic [31:0] address;     // Byte address
        logic        read;
        logic        write;
        logic [31:0] writedata;
        logic [3:0]  byteenable;
    } av_req_t;

    // Slave to master
    typedef struct packed {
        logic [31:0] readdata;    // Valid while waitrequest is low
        logic        waitrequest;
    } av_rsp_t;

endpackage

`default_nettype wire

//--- mips_alu.sv
`default_nettype none

module mips_alu (
    input  logic [31:0]               a,
    input  logic [31:0]               b,
    input  logic [4:0]                shamt,
    input  mips_isa_pkg::alu_op_e     op,
    output mips_isa_pkg::alu_result_t result
);
    import mips_isa_pkg::*;

    logic [63:0] prod_s;
    logic [63:0] prod_u;

    // Full width products, sign extended for mult
    assign prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    assign prod_u = {32'b0, a} * {32'b0, b};

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD: begin
                result.lo = a + b;
            end
            ALU_SUB: begin
                result.lo = a - b;
            end
            ALU_AND: begin
                result.lo = a & b;
            end
            ALU_OR: begin
                result.lo = a | b;
            end
            ALU_XOR: begin
                result.lo = a ^ b;
            end
            ALU_SLL: begin
                result.lo = b << shamt;   // Shifts work on rt
            end
            ALU_SRL: begin
                result.lo = b >> shamt;
            end
            ALU_MULT: begin
                {result.hi, result.lo} = prod_s;
            end
            ALU_MULTU: begin
                {result.hi, result.lo} = prod_u;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mips_regfile.sv
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  rd_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= wr_data;
        end
    end

    // $zero is hardwired
    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];
    assign v0      = regs[2];

    // Control unit must drop writes aimed at $zero
    a_no_zero_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en && wr_data != 32'd0) |-> (rd_addr != 5'd0)
    ) else $error("write of nonzero data aimed at register zero");

endmodule

`default_nettype wire

//--- mips_control.sv
`default_nettype none

module mips_control #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output avalon_pkg::av_req_t       av_req,
    input  avalon_pkg::av_rsp_t       av_rsp,
    output logic [4:0]                rs_addr,
    output logic [4:0]                rt_addr,
    output logic [4:0]                rd_addr,
    output logic                      wr_en,
    output logic [31:0]               wr_data,
    input  logic [31:0]               rs_data,
    input  logic [31:0]               rt_data,
    output mips_isa_pkg::alu_op_e     alu_op,
    output logic [31:0]               alu_a,
    output logic [31:0]               alu_b,
    output logic [4:0]                shamt,
    input  mips_isa_pkg::alu_result_t alu_result,
    output logic                      active
);
    import mips_isa_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM
    } state_e;

    state_e      state;
    logic [31:0] pc;
    instr_u      ir;
    logic [31:0] hi;
    logic [31:0] lo;

    opcode_e     opcode;
    funct_e      funct;
    logic        is_rtype;
    logic        is_jr;
    logic        is_lw;
    logic        is_sw;
    logic        is_mult;
    logic        instr_known;
    logic        exec_wb;
    logic        wb_raw;
    logic [4:0]  dest;
    logic [31:0] imm_sext;

    assign opcode   = ir.i.opcode;
    assign funct    = ir.r.funct;
    assign is_rtype = (opcode == OP_SPECIAL);
    assign is_jr    = is_rtype && (funct == FN_JR);
    assign is_lw    = (opcode == OP_LW);
    assign is_sw    = (opcode == OP_SW);
    assign is_mult  = is_rtype && (funct == FN_MULT || funct == FN_MULTU);
    assign imm_sext = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign dest     = is_rtype ? ir.r.rd : ir.i.rt;   // rd for R-type, rt for I-type

    assign rs_addr = ir.r.rs;
    assign rt_addr = ir.r.rt;
    assign rd_addr = dest;
    assign alu_a   = rs_data;
    assign alu_b   = is_rtype ? rt_data : imm_sext;   // addiu, lw, sw add the offset
    assign shamt   = ir.r.shamt;

    // ALU select and legality check
    always_comb begin
        alu_op      = ALU_ADD;
        instr_known = 1'b1;
        if (is_rtype) begin
            case (funct)
                FN_SLL:   alu_op = ALU_SLL;
                FN_SRL:   alu_op = ALU_SRL;
                FN_SUBU:  alu_op = ALU_SUB;
                FN_AND:   alu_op = ALU_AND;
                FN_OR:    alu_op = ALU_OR;
                FN_XOR:   alu_op = ALU_XOR;
                FN_MULT:  alu_op = ALU_MULT;
                FN_MULTU: alu_op = ALU_MULTU;
                FN_ADDU, FN_JR, FN_MFHI, FN_MFLO: alu_op = ALU_ADD;
                default:  instr_known = 1'b0;
            endcase
        end else begin
            instr_known = (opcode inside {OP_ADDIU, OP_LW, OP_SW});
        end
    end

    assign exec_wb = instr_known && ((is_rtype && !is_jr && !is_mult) || opcode == OP_ADDIU);

    // Register write-back
    always_comb begin
        wr_data = alu_result.lo;
        wb_raw  = 1'b0;
        if (state == S_MEM) begin
            wr_data = av_rsp.readdata;
            wb_raw  = is_lw && !av_rsp.waitrequest;
        end else if (state == S_EXEC) begin
            wb_raw = exec_wb;
            if (is_rtype && funct == FN_MFHI) begin
                wr_data = hi;
            end else if (is_rtype && funct == FN_MFLO) begin
                wr_data = lo;
            end
        end
    end

    assign wr_en = wb_raw && (dest != 5'd0);

    // Avalon master, held by state while waitrequest is high
    always_comb begin
        av_req            = '0;
        av_req.byteenable = 4'hF;
        if (state == S_FETCH) begin
            av_req.address = pc;
            av_req.read    = 1'b1;
        end else if (state == S_MEM) begin
            av_req.address   = alu_result.lo;
            av_req.read      = is_lw;
            av_req.write     = is_sw;
            av_req.writedata = rt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            pc     <= RESET_VECTOR;
            active <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pc     <= RESET_VECTOR;
                        active <= 1'b1;
                        state  <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (!av_rsp.waitrequest) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_jr && rs_data == 32'd0) begin
                        active <= 1'b0;   // Halt
                        state  <= S_IDLE;
                    end else if (is_jr) begin
                        pc    <= rs_data;
                        state <= S_FETCH;
                    end else begin
                        pc    <= pc + 32'd4;
                        state <= (is_lw || is_sw) ? S_MEM : S_FETCH;
                    end
                end
                S_MEM: begin
                    if (!av_rsp.waitrequest) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Instruction register and hi/lo
    always_ff @(posedge clk) begin
        if (state == S_FETCH && !av_rsp.waitrequest) begin
            ir <= av_rsp.readdata;
        end
        if (state == S_EXEC && is_mult) begin
            hi <= alu_result.hi;
            lo <= alu_result.lo;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((av_req.read || av_req.write) && av_rsp.waitrequest) |=> $stable(av_req)
    ) else $error("Avalon request changed under waitrequest");

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(av_req.read && av_req.write)
    ) else $error("Avalon read and write high together");

    a_known_instr: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == S_EXEC) |-> instr_known
    ) else $error("unknown instruction %08h in execute", ir);

endmodule

`default_nettype wire

//--- mips_cpu.sv
`default_nettype none

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output avalon_pkg::av_req_t av_req,
    input  avalon_pkg::av_rsp_t av_rsp,
    output logic                active,
    output logic [31:0]         register_v0
);
    import mips_isa_pkg::*;

    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [4:0]  rd_addr;
    logic        wr_en;
    logic [31:0] wr_data;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [4:0]  shamt;
    alu_op_e     alu_op;
    alu_result_t alu_result;

    mips_control #(
        .RESET_VECTOR(RESET_VECTOR)
    ) control_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .av_req     (av_req),
        .av_rsp     (av_rsp),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rd_addr    (rd_addr),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .shamt      (shamt),
        .alu_result (alu_result),
        .active     (active)
    );

    mips_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_addr (rd_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)   // $v0 seen from outside
    );

    mips_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (shamt),
        .op     (alu_op),
        .result (alu_result)
    );

endmodule

`default_nettype wire

//--- avalon_ram.sv
`default_nettype none

module avalon_ram #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  avalon_pkg::av_req_t av_req,
    output avalon_pkg::av_rsp_t av_rsp,
    input  logic                load_valid,
    input  logic [31:0]         load_addr,
    input  logic [31:0]         load_data
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int CW = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [CW-1:0] wait_cnt;
    logic          req;
    logic          ready;
    logic [AW-1:0] word_idx;

    assign req      = av_req.read || av_req.write;
    assign ready    = (wait_cnt == CW'(RAM_WAIT));
    assign word_idx = av_req.address[AW+1:2];   // Byte address to word index

    assign av_rsp.waitrequest = req && !ready;
    assign av_rsp.readdata    = mem[word_idx];

    // Counts wait cycles, restarts after each completed transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (req && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr[AW+1:2]] <= load_data;   // Preload, CPU idle
        end else if (av_req.write && ready) begin
            for (int i = 0; i < 4; i++) begin
                if (av_req.byteenable[i]) begin
                    mem[word_idx][8*i +: 8] <= av_req.writedata[8*i +: 8];
                end
            end
        end
    end

    a_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        req |-> (av_req.address[31:2] < RAM_WORDS)
    ) else $error("RAM access out of range at %08h", av_req.address);

endmodule

`default_nettype wire

//--- mips_system.sv
`default_nettype none

module mips_system #(
    parameter logic [31:0] RESET_VECTOR = 32'd4,
    parameter int          RAM_WORDS    = 256,
    parameter int          RAM_WAIT     = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        load_valid,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic        active,
    output logic [31:0] register_v0
);
    import avalon_pkg::*;

    av_req_t av_req;
    av_rsp_t av_rsp;

    mips_cpu #(
        .RESET_VECTOR(RESET_VECTOR)
    ) cpu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .av_req      (av_req),
        .av_rsp      (av_rsp),
        .active      (active),
        .register_v0 (register_v0)
    );

    // Instructions and data share one slave
    avalon_ram #(
        .RAM_WORDS(RAM_WORDS),
        .RAM_WAIT (RAM_WAIT)
    ) ram_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .av_req     (av_req),
        .av_rsp     (av_rsp),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

//--- tb_mips_system.sv
`default_nettype none

module tb_mips_system;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_VECTOR = 32'd4;
    localparam int          RAM_WORDS    = 256;
    localparam int          RAM_WAIT     = 2;
    localparam string       CASES_FILE   = "mips_cases.txt";

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } load_word_t;

    typedef struct packed {
        int          first;    // Index of the case's first word in loads
        int          count;
        logic [31:0] v0_exp;
    } test_case_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        load_valid;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        active;
    logic [31:0] register_v0;

    load_word_t  loads [$];
    test_case_t  cases [$];
    bit          cases_ready;

    always #20 clk = ~clk;

    mips_system #(
        .RESET_VECTOR(RESET_VECTOR),
        .RAM_WORDS   (RAM_WORDS),
        .RAM_WAIT    (RAM_WAIT)
    ) mips_system_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic stop_on_bad_line(input string line);
        $display("Malformed line in %s: %s", CASES_FILE, line);
        $display("Some tests failed");
        $fatal(1, "cannot parse cases file");
    endtask

    // L lines collect words, an R line closes the case
    task automatic read_cases();
        int          fd;
        int          n;
        int          first;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        fd    = $fopen(CASES_FILE, "r");
        first = 0;
        if (fd == 0) begin
            $display("Could not open %s for reading", CASES_FILE);
            $display("Some tests failed");
            $fatal(1, "missing cases file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] == "L") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                if (n != 2) begin
                    stop_on_bad_line(line);
                end
                loads.push_back('{addr: a, data: d});
            end else if (line.len() > 1 && line[0] == "R") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h", d);
                if (n != 1) begin
                    stop_on_bad_line(line);
                end
                cases.push_back('{first: first, count: loads.size() - first, v0_exp: d});
                first = loads.size();
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            $display("No cases found in %s", CASES_FILE);
            $display("Some tests failed");
            $fatal(1, "empty cases file");
        end
    endtask

    // One strobe per word, random idle gap after each
    task automatic load_program(input test_case_t tc);
        load_word_t w;
        int         gap;
        int         k;
        for (k = 0; k < tc.count; k++) begin
            w = loads[tc.first + k];
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= w.addr;
            load_data  <= w.data;
            gap = $urandom % 4;
            if (gap > 0) begin
                @(posedge clk);
                load_valid <= 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic run_program(input test_case_t tc);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_bit("active", active, 1'b1);
        while (active) begin
            @(negedge clk);
        end
        check_word("register_v0", register_v0, tc.v0_exp);
    endtask

    initial begin : watchdog
        int limit;
        wait (cases_ready);
        limit = (loads.size() * 4 + 50) * (RAM_WAIT + 4);
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before all cases finished", limit);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    initial begin : main
        int i;
        void'($urandom(33));
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        cases_ready = 1'b0;
        read_cases();
        cases_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("active", active, 1'b0);   // Idle until start
        check_word("register_v0", register_v0, 32'h0);

        for (i = 0; i < cases.size(); i++) begin
            $display("Case %0d: %0d words, $v0 should be %08h",
                     i, cases[i].count, cases[i].v0_exp);
            load_program(cases[i]);
            run_program(cases[i]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_cases.txt
# L <byte address> <instruction or data word>, hex, loads one word
# R <expected $v0>, hex, starts the program at 0x4 and checks $v0 after the halt
# Case 0: addiu, addu, subu, and, or, xor, sll, srl
L 00000004 24081234  addiu $t0,$0,0x1234
L 00000008 2409FFFD  addiu $t1,$0,-3
L 0000000C 01095021  addu  $t2,$t0,$t1
L 00000010 000A5A00  sll   $t3,$t2,8
L 00000014 01695823  subu  $t3,$t3,$t1
L 00000018 01685026  xor   $t2,$t3,$t0
L 0000001C 000A5902  srl   $t3,$t2,4
L 00000020 01695824  and   $t3,$t3,$t1
L 00000024 016A1025  or    $v0,$t3,$t2
L 00000028 03E00008  jr    $ra
R 00132337
# Case 1: signed mult, -855 times 0x682D5
L 00000004 2408FCA9  addiu $t0,$0,-855
L 00000008 24090068  addiu $t1,$0,0x68
L 0000000C 00094B00  sll   $t1,$t1,12
L 00000010 252902D5  addiu $t1,$t1,0x2D5
L 00000014 01090018  mult  $t0,$t1
L 00000018 00005812  mflo  $t3
L 0000001C 00005010  mfhi  $t2
L 00000020 254A0001  addiu $t2,$t2,1
L 00000024 016A1021  addu  $v0,$t3,$t2
L 00000028 03E00008  jr    $ra
R EA410A9D
# Case 2: multu, operand with the top bit set
L 00000004 24088000  addiu $t0,$0,0x8000
L 00000008 24097FFF  addiu $t1,$0,0x7FFF
L 0000000C 01090019  multu $t0,$t1
L 00000010 00005010  mfhi  $t2
L 00000014 00005812  mflo  $t3
L 00000018 014B1026  xor   $v0,$t2,$t3
L 0000001C 03E00008  jr    $ra
R C000FFFE
# Case 3: sw then lw through the wait-state bus
L 00000208 0BADF00D  old data, overwritten by sw
L 00000004 24080200  addiu $t0,$0,0x200
L 00000008 2409BEEF  addiu $t1,$0,0xBEEF
L 0000000C 00094900  sll   $t1,$t1,4
L 00000010 AD090008  sw    $t1,8($t0)
L 00000014 24020001  addiu $v0,$0,1
L 00000018 8D020008  lw    $v0,8($t0)
L 0000001C 03E00008  jr    $ra
R FFFBEEF0
# Case 4: short rerun, replaces the previous $v0
L 00000004 24025A5A  addiu $v0,$0,0x5A5A
L 00000008 03E00008  jr    $ra
R 00005A5A

//--- compile.f
mips_isa_pkg.sv
avalon_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_control.sv
mips_cpu.sv
avalon_ram.sv
mips_system.sv
tb_mips_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_mips_system -o tb_mips_system
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_mips_system 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
